/* hw/remap_mem_cfg_pkg.sv */
`default_nettype none

package remap_mem_cfg_pkg;

  // data word width.
  localparam int WIDTH = 16;

  // virtual banks come from the low address bits.
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;

  // rows come from the high address bits.
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  localparam int NUMADDR = NUMVBNK * NUMVROW; // flat address space.
  localparam int BITADDR = BITVBNK + BITVROW;

  // one spare physical bank absorbs the conflicting write.
  localparam int NUMPBNK = NUMVBNK + 1;
  localparam int BITPBNK = 3;

  localparam int BITPADR = BITPBNK + BITVROW; // physical bank over row.

endpackage

`default_nettype wire

/* hw/remap_mem_types_pkg.sv */
`default_nettype none

package remap_mem_types_pkg;

  import remap_mem_cfg_pkg::*;

  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_READ,
    BANK_WRITE
  } bank_op_e;

  typedef struct packed {
    logic               en;
    logic [BITADDR-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic               en;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   data;
  } wr_req_t;

  typedef struct packed {
    logic               vld;
    logic [WIDTH-1:0]   data;
    logic [BITPADR-1:0] padr; // bank in the upper bits, row in the lower.
  } rd_rsp_t;

  typedef struct packed {
    logic [NUMVBNK-1:0][BITPBNK-1:0] pbnk; // physical bank per virtual bank.
    logic [BITPBNK-1:0]              free;
  } map_row_t;

  typedef struct packed {
    bank_op_e           op;
    logic [BITVROW-1:0] row;
    logic [WIDTH-1:0]   data;
  } bank_cmd_t;

  typedef struct packed {
    logic               en;
    logic [BITVROW-1:0] row;
    logic [BITVBNK-1:0] vbnk;
    logic [BITPBNK-1:0] pbnk;
  } map_upd_t;

endpackage

`default_nettype wire

/* hw/sp_bank.sv */
`default_nettype none

module sp_bank
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
(
  input  logic             clk,
  input  bank_cmd_t        cmd,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] mem [NUMVROW];

  always_ff @(posedge clk) begin
    case (cmd.op)
      BANK_WRITE: begin
        mem[cmd.row] <= cmd.data;
      end
      BANK_READ: begin
        dout <= mem[cmd.row]; // holds until the next read of this bank.
      end
      default: begin
      end
    endcase
  end

  // the steering only ever encodes idle, read or write.
  assert_bank_op_legal: assert property (
    @(posedge clk) !$isunknown(cmd.op) |-> (cmd.op inside {BANK_IDLE, BANK_READ, BANK_WRITE})
  );

endmodule

`default_nettype wire

/* hw/bank_map_table.sv */
`default_nettype none

module bank_map_table
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [BITVROW-1:0] rd_row,
  input  logic [BITVROW-1:0] wr_row,
  output map_row_t           rd_map,
  output map_row_t           wr_map,
  input  map_upd_t           upd
);

  map_row_t map_mem [NUMVROW];

  function automatic map_row_t identity_row();
    map_row_t r;
    for (int v = 0; v < NUMVBNK; v++) begin
      r.pbnk[v] = BITPBNK'(v);
    end
    r.free = BITPBNK'(NUMVBNK);
    return r;
  endfunction

  // true when no two of the five indexes of a row point at the same bank.
  function automatic logic row_distinct(map_row_t r);
    logic [BITPBNK-1:0] idx [NUMPBNK];
    logic               ok;
    for (int v = 0; v < NUMVBNK; v++) begin
      idx[v] = r.pbnk[v];
    end
    idx[NUMVBNK] = r.free;
    ok = 1'b1;
    for (int i = 0; i < NUMPBNK; i++) begin
      for (int j = i + 1; j < NUMPBNK; j++) begin
        if (idx[i] == idx[j]) begin
          ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUMVROW; r++) begin
        map_mem[r] <= identity_row();
      end
    end else if (upd.en) begin
      map_mem[upd.row].pbnk[upd.vbnk] <= upd.pbnk;
      map_mem[upd.row].free <= map_mem[upd.row].pbnk[upd.vbnk]; // old bank is freed.
    end
  end

  assign rd_map = map_mem[rd_row];
  assign wr_map = map_mem[wr_row];

  // A swap must leave the row as a permutation of the physical banks.
  assert_swap_keeps_row_distinct: assert property (
    @(posedge clk) disable iff (rst) upd.en |=> row_distinct(map_mem[$past(upd.row)])
  );

endmodule

`default_nettype wire

/* hw/bank_steer.sv */
`default_nettype none

module bank_steer
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
(
  input  rd_req_t            rd_req,
  input  wr_req_t            wr_req,
  input  map_row_t           rd_map,
  input  map_row_t           wr_map,
  output logic [BITVROW-1:0] rd_row,
  output logic [BITVROW-1:0] wr_row,
  output map_upd_t           upd,
  output bank_cmd_t          bank_cmd [NUMPBNK],
  output logic [BITPBNK-1:0] rd_sel,
  output logic               rd_go
);

  logic [BITVBNK-1:0] rd_vbnk;
  logic [BITVBNK-1:0] wr_vbnk;
  logic [BITPBNK-1:0] rd_pbnk;
  logic [BITPBNK-1:0] wr_home;
  logic [BITPBNK-1:0] wr_pbnk;
  logic               conflict;

  assign rd_vbnk = rd_req.addr[BITVBNK-1:0];
  assign rd_row  = rd_req.addr[BITADDR-1:BITVBNK];
  assign wr_vbnk = wr_req.addr[BITVBNK-1:0];
  assign wr_row  = wr_req.addr[BITADDR-1:BITVBNK];

  assign rd_pbnk = rd_map.pbnk[rd_vbnk];
  assign wr_home = wr_map.pbnk[wr_vbnk];

  // the read keeps its bank and the write moves to its row's spare.
  assign conflict = rd_req.en && wr_req.en && (wr_home == rd_pbnk);
  assign wr_pbnk  = conflict ? wr_map.free : wr_home;

  always_comb begin
    for (int b = 0; b < NUMPBNK; b++) begin
      bank_cmd[b].op   = BANK_IDLE;
      bank_cmd[b].row  = wr_row;
      bank_cmd[b].data = wr_req.data;
      if (rd_req.en && (rd_pbnk == BITPBNK'(b))) begin
        bank_cmd[b].op  = BANK_READ;
        bank_cmd[b].row = rd_row;
      end else if (wr_req.en && (wr_pbnk == BITPBNK'(b))) begin
        bank_cmd[b].op = BANK_WRITE;
      end
    end
  end

  assign upd.en   = conflict;
  assign upd.row  = wr_row;
  assign upd.vbnk = wr_vbnk;
  assign upd.pbnk = wr_map.free;

  assign rd_sel = rd_pbnk;
  assign rd_go  = rd_req.en;

  // relies on every map row staying a permutation of the banks.
  always_comb begin
    if (rd_req.en && wr_req.en) begin
      assert_rd_wr_bank_differ: assert final (rd_pbnk != wr_pbnk);
    end
  end

endmodule

`default_nettype wire

/* hw/read_return.sv */
`default_nettype none

module read_return
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               rd_go,
  input  logic [BITPBNK-1:0] rd_sel,
  input  logic [BITVROW-1:0] rd_row,
  input  logic [WIDTH-1:0]   bank_dout [NUMPBNK],
  output rd_rsp_t            rd_rsp
);

  logic               go_q;
  logic [BITPBNK-1:0] sel_q;
  logic [BITVROW-1:0] row_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      go_q <= 1'b0;
    end else begin
      go_q <= rd_go;
    end
  end

  always_ff @(posedge clk) begin
    sel_q <= rd_sel; // aligned with the bank's registered read.
    row_q <= rd_row;
  end

  assign rd_rsp.vld  = go_q;
  assign rd_rsp.data = bank_dout[sel_q];
  assign rd_rsp.padr = {sel_q, row_q};

endmodule

`default_nettype wire

/* hw/remap_mem_top.sv */
`default_nettype none

module remap_mem_top
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  rd_req_t rd_req,
  input  wr_req_t wr_req,
  output rd_rsp_t rd_rsp
);

  logic [BITVROW-1:0] rd_row;
  logic [BITVROW-1:0] wr_row;
  map_row_t           rd_map;
  map_row_t           wr_map;
  map_upd_t           upd;
  bank_cmd_t          bank_cmd [NUMPBNK];
  logic [WIDTH-1:0]   bank_dout [NUMPBNK];
  logic [BITPBNK-1:0] rd_sel;
  logic               rd_go;

  bank_map_table bank_map_table_inst (
    .clk    (clk),
    .rst    (rst),
    .rd_row (rd_row),
    .wr_row (wr_row),
    .rd_map (rd_map),
    .wr_map (wr_map),
    .upd    (upd)
  );

  bank_steer bank_steer_inst (
    .rd_req   (rd_req),
    .wr_req   (wr_req),
    .rd_map   (rd_map),
    .wr_map   (wr_map),
    .rd_row   (rd_row),
    .wr_row   (wr_row),
    .upd      (upd),
    .bank_cmd (bank_cmd),
    .rd_sel   (rd_sel),
    .rd_go    (rd_go)
  );

  for (genvar b = 0; b < NUMPBNK; b++) begin : g_bank
    sp_bank sp_bank_inst (
      .clk  (clk),
      .cmd  (bank_cmd[b]),
      .dout (bank_dout[b])
    );
  end

  read_return read_return_inst (
    .clk       (clk),
    .rst       (rst),
    .rd_go     (rd_go),
    .rd_sel    (rd_sel),
    .rd_row    (rd_row),
    .bank_dout (bank_dout),
    .rd_rsp    (rd_rsp)
  );

endmodule

`default_nettype wire

/* verification/remap_mem_checker.sv */
`default_nettype none

module remap_mem_checker
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  rd_req_t rd_req,
  input  wr_req_t wr_req,
  input  rd_rsp_t rd_rsp,
  input  int      test_id,
  input  logic    test_end,
  output int      total_checks,
  output int      total_errors
);

  logic [BITPBNK-1:0] model_map [NUMVROW][NUMVBNK];
  logic [BITPBNK-1:0] model_free [NUMVROW];
  logic [WIDTH-1:0]   model_data [NUMADDR];
  logic               model_known [NUMADDR]; // banks power up without a defined value.

  logic               armed = 1'b0;
  logic               exp_vld = 1'b0;
  logic               exp_known;
  logic [WIDTH-1:0]   exp_data;
  logic [BITPADR-1:0] exp_padr;
  logic [BITADDR-1:0] exp_addr;
  logic [BITVBNK-1:0] rd_vbnk;
  logic [BITVROW-1:0] rd_row;
  logic [BITPBNK-1:0] rd_pbnk;
  logic [BITVBNK-1:0] wr_vbnk;
  logic [BITVROW-1:0] wr_row;
  logic [BITPBNK-1:0] wr_home;
  int                 checks_q = 0;
  int                 errors_q = 0;
  int                 checks_mark = 0;
  int                 errors_mark = 0;
  int                 test_errs;

  assign total_checks = checks_q;
  assign total_errors = errors_q;

  // inputs change on the falling edge, so the rising edge sees them settled.
  always @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUMVROW; r++) begin
        for (int v = 0; v < NUMVBNK; v++) begin
          model_map[r][v] = BITPBNK'(v);
        end
        model_free[r] = BITPBNK'(NUMVBNK);
      end
      for (int a = 0; a < NUMADDR; a++) begin
        model_known[a] = 1'b0;
      end
      armed   = 1'b0;
      exp_vld = 1'b0;
    end else begin
      armed     = 1'b1;
      exp_vld   = rd_req.en;
      rd_vbnk   = rd_req.addr[BITVBNK-1:0];
      rd_row    = rd_req.addr[BITADDR-1:BITVBNK];
      rd_pbnk   = model_map[rd_row][rd_vbnk];
      exp_addr  = rd_req.addr;
      exp_padr  = {rd_pbnk, rd_row};
      exp_data  = model_data[rd_req.addr]; // taken before this cycle's write.
      exp_known = model_known[rd_req.addr];
      if (wr_req.en) begin
        wr_vbnk = wr_req.addr[BITVBNK-1:0];
        wr_row  = wr_req.addr[BITADDR-1:BITVBNK];
        wr_home = model_map[wr_row][wr_vbnk];
        if (rd_req.en && (wr_home == rd_pbnk)) begin
          model_map[wr_row][wr_vbnk] = model_free[wr_row]; // write moves to the spare.
          model_free[wr_row] = wr_home;
        end
        model_data[wr_req.addr]  = wr_req.data;
        model_known[wr_req.addr] = 1'b1;
      end
      if (test_end) begin
        test_errs = errors_q - errors_mark;
        $display("test %0d %s: %0d checks, %0d errors", test_id,
                 (test_errs == 0) ? "passed" : "failed", checks_q - checks_mark, test_errs);
        checks_mark = checks_q;
        errors_mark = errors_q;
      end
    end
  end

  // the response is registered, so it is settled by the falling edge.
  always @(negedge clk) begin
    if (armed) begin
      if (rd_rsp.vld !== exp_vld) begin
        errors_q++;
        if (exp_vld) begin
          $display("error: no rd_rsp.vld one cycle after the read of address %h", exp_addr);
        end else begin
          $display("error: rd_rsp.vld went high with no read in the cycle before");
        end
      end else if (exp_vld) begin
        checks_q++;
        if (rd_rsp.padr !== exp_padr) begin
          errors_q++;
          $display("mismatch rd_rsp.padr: expected %h, got %h (address %h)",
                   exp_padr, rd_rsp.padr, exp_addr);
        end
        if (exp_known && (rd_rsp.data !== exp_data)) begin
          errors_q++;
          $display("mismatch rd_rsp.data: expected %h, got %h (address %h)",
                   exp_data, rd_rsp.data, exp_addr);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/remap_mem_tb.sv */
`default_nettype none

module remap_mem_tb
  import remap_mem_cfg_pkg::*, remap_mem_types_pkg::*;
();

  localparam int LEN_RESET_MAP  = 64;
  localparam int LEN_FILL       = 64;
  localparam int LEN_STEER      = 200;
  localparam int LEN_SAME_ADDR  = 100;
  localparam int LEN_RANDOM     = 2000;
  localparam int TIMEOUT_CYCLES =
    2 * (LEN_RESET_MAP + LEN_FILL + LEN_STEER + LEN_SAME_ADDR + LEN_RANDOM);
  localparam int NUM_TESTS      = 5;

  logic    clk = 1'b0;
  logic    rst;
  rd_req_t rd_req;
  wr_req_t wr_req;
  rd_rsp_t rd_rsp;
  int      test_id;
  logic    test_end;
  int      total_checks;
  int      total_errors;
  int      cycle_count = 0;

  always #20 clk = ~clk;

  remap_mem_top remap_mem_top_inst (
    .clk    (clk),
    .rst    (rst),
    .rd_req (rd_req),
    .wr_req (wr_req),
    .rd_rsp (rd_rsp)
  );

  remap_mem_checker remap_mem_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .rd_rsp       (rd_rsp),
    .test_id      (test_id),
    .test_end     (test_end),
    .total_checks (total_checks),
    .total_errors (total_errors)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic drive_cycle(input logic rd_en, input logic [BITADDR-1:0] rd_addr,
                             input logic wr_en, input logic [BITADDR-1:0] wr_addr,
                             input logic [WIDTH-1:0] wr_data);
    @(negedge clk);
    rd_req.en   = rd_en;
    rd_req.addr = rd_addr;
    wr_req.en   = wr_en;
    wr_req.addr = wr_addr;
    wr_req.data = wr_data;
  endtask

  // idles so the last response is compared before the checker reports.
  task automatic close_test();
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
    test_end = 1'b1;
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
    test_end = 1'b0;
    test_id++;
  endtask

  initial begin
    logic [BITADDR-1:0] addr_a;
    logic [BITADDR-1:0] addr_b;
    logic               rd_en;
    logic               wr_en;
    int unsigned        pick;
    rst      = 1'b1;
    rd_req   = '0;
    wr_req   = '0;
    test_id  = 1;
    test_end = 1'b0;
    void'($urandom(32'hecd03ff1));
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // identity map after reset.
    for (int a = 0; a < LEN_RESET_MAP; a++) begin
      drive_cycle(1'b1, BITADDR'(a), 1'b0, '0, '0);
    end
    close_test();

    // each address is read back one cycle after its write.
    for (int a = 0; a <= LEN_FILL; a++) begin
      drive_cycle(a > 0, BITADDR'(a - 1), a < LEN_FILL, BITADDR'(a), WIDTH'($urandom));
    end
    close_test();

    // same virtual bank in two rows sends the write to the spare bank while both rows agree.
    for (int k = 0; k < LEN_STEER / 4; k++) begin
      addr_a = {BITVROW'(k % NUMVROW), BITVBNK'(k % NUMVBNK)};
      addr_b = {BITVROW'((k + 5) % NUMVROW), BITVBNK'(k % NUMVBNK)};
      drive_cycle(1'b1, addr_a, 1'b1, addr_b, WIDTH'($urandom));
      drive_cycle(1'b1, addr_b, 1'b0, '0, '0);
      drive_cycle(1'b1, addr_a, 1'b0, '0, '0);
      drive_cycle(1'b0, '0, 1'b0, '0, '0);
    end
    close_test();

    for (int k = 0; k < LEN_SAME_ADDR / 2; k++) begin
      addr_a = BITADDR'($urandom);
      drive_cycle(1'b1, addr_a, 1'b1, addr_a, WIDTH'($urandom));
      drive_cycle(1'b1, addr_a, 1'b0, '0, '0);
    end
    close_test();

    // half of the pairs share an address or a virtual bank.
    for (int k = 0; k < LEN_RANDOM; k++) begin
      rd_en  = ($urandom % 10) != 0;
      wr_en  = ($urandom % 10) != 0;
      addr_a = BITADDR'($urandom);
      pick   = $urandom % 4;
      if (pick == 0) begin
        addr_b = addr_a;
      end else if (pick == 1) begin
        addr_b = {BITVROW'($urandom), addr_a[BITVBNK-1:0]};
      end else begin
        addr_b = BITADDR'($urandom);
      end
      drive_cycle(rd_en, addr_a, wr_en, addr_b, WIDTH'($urandom));
    end
    close_test();
    @(posedge clk);

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, total_checks, total_errors);
    if ((total_errors == 0) && (total_checks > 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* remap_mem.f */
hw/remap_mem_cfg_pkg.sv
hw/remap_mem_types_pkg.sv
hw/sp_bank.sv
hw/bank_map_table.sv
hw/bank_steer.sv
hw/read_return.sv
hw/remap_mem_top.sv
verification/remap_mem_checker.sv
verification/remap_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= remap_mem_tb
FILELIST  ?= remap_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
